// ==== include/nabp_params.svh ====
`ifndef NABP_PARAMS_SVH
`define NABP_PARAMS_SVH

// ------------------------------
// angle range and decode thresholds
// ------------------------------
// angles in degrees, 0 to 179
`define kAngleLength 8
`define kAngle45 45
`define kAngle90 90
`define kAngle135 135

// ------------------------------
// data path widths and counts
// ------------------------------
// signed filtered sample
`define kFilteredDataLength 12
// one tap per PE
`define kNoOfPartitions 4
// lines per angle
`define kPartitionSize 4
`define kPartitionSizeLength 2
// filtered RAM address
`define kSLength 10
// signed offset accumulator
`define kAccuLength 16
// pe_en window per line
`define kShiftCycles 6

`endif

// ==== logic/nabp_pkg.sv ====
package nabp_pkg;

    // ------------------------------
    // swap control states
    // ------------------------------
    typedef enum logic [3:0] {
        ctrl_ready,
        ctrl_setup_1,
        ctrl_setup_2,
        ctrl_setup_3,
        ctrl_fill,
        ctrl_fill_and_shift,
        ctrl_angle_setup_1,
        ctrl_angle_setup_2,
        ctrl_angle_setup_3,
        ctrl_shift
    } ctrl_state_t;

    // per buffer states
    typedef enum logic [2:0] {
        sw_idle,
        sw_fill,
        sw_fill_wait,
        sw_wait_swap,
        sw_shift
    } sw_state_t;

    // pe scan decode, one bit each
    typedef enum logic {
        scan_x,
        scan_y
    } scan_mode_t;

    typedef enum logic {
        dir_forward,
        dir_reverse
    } scan_direction_t;

endpackage

// ==== logic/nabp_swap_if.sv ====
`timescale 1ns/1ps
`include "nabp_params.svh"

interface nabp_swap_if;

    // fill parameters, shared by both buffers
    logic [`kAccuLength-1:0] mp_accu_init;
    logic [`kAccuLength-1:0] mp_accu_base;
    // one-cycle strobes from the control
    logic swap_ack;
    logic next_itr_ack;
    // levels from the buffer
    logic swap;
    logic next_itr;
    logic pe_en;
    // taps held for the PEs
    logic [`kFilteredDataLength*`kNoOfPartitions-1:0] pe_taps;

    // control side
    modport ctrl (
        output mp_accu_init, mp_accu_base, swap_ack, next_itr_ack,
        input  swap, next_itr, pe_en, pe_taps
    );

    // buffer side
    modport sw (
        input  mp_accu_init, mp_accu_base, swap_ack, next_itr_ack,
        output swap, next_itr, pe_en, pe_taps
    );

endinterface

// ==== logic/nabp_angle_lut.sv ====
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_angle_lut (
    input  logic                    clk,
    input  logic [`kAngleLength-1:0] angle,
    output logic [`kAccuLength-1:0] mp_accu_part,
    output logic [`kAccuLength-1:0] mp_accu_base
);

    // one entry per angle code
    localparam int kEntries = 1 << `kAngleLength;
    // step repeats every 8 degrees
    localparam int kStepPeriod = 8;
    // fixed part of the map offset
    localparam int kOffsetBase = 16;

    logic [`kAccuLength-1:0] step_table [kEntries];
    logic [`kAccuLength-1:0] offset_table [kEntries];

    // ------------------------------
    // table contents
    // ------------------------------
    for (genvar i = 0; i < kEntries; i++)
    begin : g_entry
        localparam int kStep = (i % kStepPeriod) + 1;
        // offset of line 0, the last line starts at the base
        localparam int kOffset = kStep * (`kPartitionSize - 1) + kOffsetBase;
        assign step_table[i] = `kAccuLength'(kStep);
        assign offset_table[i] = `kAccuLength'(kOffset);
    end

    // registered read, valid one cycle after angle changes
    always_ff @(posedge clk)
    begin
        mp_accu_part <= offset_table[angle];
        mp_accu_base <= step_table[angle];
    end

endmodule

// ==== logic/nabp_swappable.sv ====
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_swappable (
    input  logic                                clk,
    input  logic                                reset_n,
    nabp_swap_if.sw                             sw,
    input  logic signed [`kFilteredDataLength-1:0] fr_val,
    output logic [`kSLength-1:0]                fr_s_val
);

    localparam int kTapIdxLength = $clog2(`kNoOfPartitions);
    localparam int kShiftCntLength = $clog2(`kShiftCycles);
    localparam logic [kTapIdxLength-1:0] kLastTap = kTapIdxLength'(`kNoOfPartitions - 1);
    localparam logic [kShiftCntLength-1:0] kLastShift = kShiftCntLength'(`kShiftCycles - 1);

    nabp_pkg::sw_state_t state;
    // address issue counter
    logic [kTapIdxLength-1:0] fill_cnt;
    // pe_en window counter
    logic [kShiftCntLength-1:0] shift_cnt;
    // address accumulator and its step, latched at the kick
    logic [`kAccuLength-1:0] accu;
    logic [`kAccuLength-1:0] step;
    // RAM answers one cycle later, so capture trails the address
    logic cap_en;
    logic [kTapIdxLength-1:0] cap_idx;
    logic [`kNoOfPartitions-1:0][`kFilteredDataLength-1:0] taps;

    // ------------------------------
    // buffer FSM
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_pkg::sw_idle;
            fill_cnt <= '0;
            shift_cnt <= '0;
            cap_en <= 1'b0;
        end
        else
        begin
            // sample returns for every address issued
            cap_en <= (state == nabp_pkg::sw_fill);
            case (state)
                nabp_pkg::sw_idle:
                    if (sw.next_itr_ack)
                    begin
                        state <= nabp_pkg::sw_fill;
                        fill_cnt <= '0;
                    end
                nabp_pkg::sw_fill:
                begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == kLastTap)
                        state <= nabp_pkg::sw_fill_wait;
                end
                // last sample still in flight
                nabp_pkg::sw_fill_wait:
                    state <= nabp_pkg::sw_wait_swap;
                // hold the filled taps as long as needed
                nabp_pkg::sw_wait_swap:
                    if (sw.swap_ack)
                    begin
                        state <= nabp_pkg::sw_shift;
                        shift_cnt <= '0;
                    end
                nabp_pkg::sw_shift:
                begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == kLastShift)
                        state <= nabp_pkg::sw_idle;
                end
                default:
                    state <= nabp_pkg::sw_idle;
            endcase
        end
    end

    // ------------------------------
    // address and tap path
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (state == nabp_pkg::sw_idle && sw.next_itr_ack)
        begin
            accu <= sw.mp_accu_init;
            step <= sw.mp_accu_base;
        end
        else if (state == nabp_pkg::sw_fill)
            accu <= accu + step;
        cap_idx <= fill_cnt;
        if (cap_en)
            taps[cap_idx] <= fr_val;
    end

    // address truncated to RAM width
    assign fr_s_val = accu[`kSLength-1:0];

    assign sw.swap = (state == nabp_pkg::sw_wait_swap);
    assign sw.next_itr = (state == nabp_pkg::sw_idle);
    assign sw.pe_en = (state == nabp_pkg::sw_shift);
    assign sw.pe_taps = taps;

endmodule

// ==== logic/nabp_swap_control.sv ====
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_swap_control (
    input  logic                                           clk,
    input  logic                                           reset_n,
    input  logic [`kAngleLength-1:0]                       fr_angle,
    input  logic                                           fr_has_next_angle,
    input  logic                                           fr_next_angle_ack,
    output logic                                           fr_next_angle,
    input  logic [`kAccuLength-1:0]                        mp_accu_part,
    input  logic [`kAccuLength-1:0]                        mp_accu_base,
    nabp_swap_if.ctrl                                      sw0,
    nabp_swap_if.ctrl                                      sw1,
    output logic                                           pe_reset,
    output logic                                           pe_kick,
    output logic                                           pe_en,
    output nabp_pkg::scan_mode_t                           pe_scan_mode,
    output nabp_pkg::scan_direction_t                      pe_scan_direction,
    output logic [`kFilteredDataLength*`kNoOfPartitions-1:0] pe_taps
);

    localparam logic [`kPartitionSizeLength-1:0] kLastLine =
        `kPartitionSizeLength'(`kPartitionSize - 1);

    nabp_pkg::ctrl_state_t state;
    nabp_pkg::ctrl_state_t next_state;
    // 0: sw0 fills, sw1 presents
    logic sw_sel;
    // low through reset, keeps the angle request quiet
    logic run_en;
    logic [`kPartitionSizeLength-1:0] line_itr;
    logic last_line;
    // start offset of the next line to kick
    logic [`kAccuLength-1:0] mp_accu_init;
    logic [`kAngleLength-1:0] pe_angle;
    logic in_setup;
    logic in_fill;
    logic swap_ready;
    // role views, swa fills and swb presents
    logic swa_swap;
    logic swa_next_itr;
    logic swb_next_itr;
    logic swa_next_itr_ack;
    logic swb_next_itr_ack;
    logic swap_ack;

    // ------------------------------
    // role multiplexing
    // ------------------------------
    assign swa_swap = sw_sel ? sw1.swap : sw0.swap;
    assign swa_next_itr = sw_sel ? sw1.next_itr : sw0.next_itr;
    assign swb_next_itr = sw_sel ? sw0.next_itr : sw1.next_itr;
    assign sw0.swap_ack = !sw_sel && swap_ack;
    assign sw1.swap_ack = sw_sel && swap_ack;
    assign sw0.next_itr_ack = sw_sel ? swb_next_itr_ack : swa_next_itr_ack;
    assign sw1.next_itr_ack = sw_sel ? swa_next_itr_ack : swb_next_itr_ack;
    assign sw0.mp_accu_init = mp_accu_init;
    assign sw1.mp_accu_init = mp_accu_init;
    assign sw0.mp_accu_base = mp_accu_base;
    assign sw1.mp_accu_base = mp_accu_base;
    // PEs always see the presenting buffer
    assign pe_taps = sw_sel ? sw0.pe_taps : sw1.pe_taps;
    assign pe_en = sw_sel ? sw0.pe_en : sw1.pe_en;

    // ------------------------------
    // strobes and angle request
    // ------------------------------
    assign in_setup = (state == nabp_pkg::ctrl_setup_1) || (state == nabp_pkg::ctrl_setup_2) ||
                      (state == nabp_pkg::ctrl_setup_3) ||
                      (state == nabp_pkg::ctrl_angle_setup_1) ||
                      (state == nabp_pkg::ctrl_angle_setup_2) ||
                      (state == nabp_pkg::ctrl_angle_setup_3);
    assign in_fill = (state == nabp_pkg::ctrl_fill) || (state == nabp_pkg::ctrl_fill_and_shift);
    assign last_line = (line_itr == kLastLine);
    // swa holds a full line and swb has finished its window
    assign swap_ready = in_fill && swa_swap && swb_next_itr;
    // first kick of a run
    assign swa_next_itr_ack = (state == nabp_pkg::ctrl_setup_3) && swa_next_itr;
    // swap within an angle, the final swap, or after the angle bubble
    assign swap_ack = (state == nabp_pkg::ctrl_angle_setup_3) ||
                      (swap_ready && (!last_line || !fr_has_next_angle));
    // kick the freed buffer unless the run is out of lines
    assign swb_next_itr_ack = (state == nabp_pkg::ctrl_angle_setup_3) ||
                              (swap_ready && !last_line);
    // held until the ack, only while nothing else can move
    assign fr_next_angle = run_en && fr_has_next_angle &&
                           ((state == nabp_pkg::ctrl_ready) || (swap_ready && last_line));
    assign pe_kick = swap_ack;
    assign pe_reset = (state == nabp_pkg::ctrl_setup_3);

    // ------------------------------
    // state, role select and line count
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_pkg::ctrl_ready;
            sw_sel <= 1'b0;
            run_en <= 1'b0;
            line_itr <= '0;
            pe_angle <= '0;
        end
        else
        begin
            state <= next_state;
            run_en <= 1'b1;
            if (swap_ack)
                sw_sel <= !sw_sel;
            // angle_setup_3 kicks line 0, so clear wins over count
            if (in_setup)
                line_itr <= '0;
            else if (swb_next_itr_ack)
                line_itr <= line_itr + 1'b1;
            // angle of the line now presented
            if (in_fill && swap_ack)
                pe_angle <= fr_angle;
        end
    end

    // table output valid in setup_2, each kick then steps one line back
    always_ff @(posedge clk)
    begin
        if (state == nabp_pkg::ctrl_setup_2 || state == nabp_pkg::ctrl_angle_setup_2)
            mp_accu_init <= mp_accu_part;
        else if (swa_next_itr_ack || swb_next_itr_ack)
            mp_accu_init <= mp_accu_init - mp_accu_base;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ctrl_ready:
                if (fr_next_angle && fr_next_angle_ack)
                    next_state = nabp_pkg::ctrl_setup_1;
            nabp_pkg::ctrl_setup_1:
                next_state = nabp_pkg::ctrl_setup_2;
            nabp_pkg::ctrl_setup_2:
                next_state = nabp_pkg::ctrl_setup_3;
            nabp_pkg::ctrl_setup_3:
                if (swa_next_itr)
                    next_state = nabp_pkg::ctrl_fill;
            nabp_pkg::ctrl_fill, nabp_pkg::ctrl_fill_and_shift:
                if (swap_ready)
                begin
                    if (!last_line)
                        next_state = nabp_pkg::ctrl_fill_and_shift;
                    else if (!fr_has_next_angle)
                        next_state = nabp_pkg::ctrl_shift;
                    else if (fr_next_angle_ack)
                        next_state = nabp_pkg::ctrl_angle_setup_1;
                end
            // three cycle bubble for the new angle
            nabp_pkg::ctrl_angle_setup_1:
                next_state = nabp_pkg::ctrl_angle_setup_2;
            nabp_pkg::ctrl_angle_setup_2:
                next_state = nabp_pkg::ctrl_angle_setup_3;
            nabp_pkg::ctrl_angle_setup_3:
                next_state = nabp_pkg::ctrl_fill_and_shift;
            // last window of the run
            nabp_pkg::ctrl_shift:
                if (swb_next_itr)
                    next_state = nabp_pkg::ctrl_ready;
            default:
                next_state = nabp_pkg::ctrl_ready;
        endcase
    end

    // scan decode of the presented angle
    assign pe_scan_mode = (pe_angle < `kAngle45 || pe_angle >= `kAngle135) ?
                          nabp_pkg::scan_x : nabp_pkg::scan_y;
    assign pe_scan_direction = (pe_angle < `kAngle90) ?
                               nabp_pkg::dir_forward : nabp_pkg::dir_reverse;

endmodule

// ==== logic/nabp_processing_top.sv ====
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_processing_top (
    input  logic                                           clk,
    input  logic                                           reset_n,
    // angle source
    input  logic [`kAngleLength-1:0]                       fr_angle,
    input  logic                                           fr_has_next_angle,
    input  logic                                           fr_next_angle_ack,
    output logic                                           fr_next_angle,
    // filtered RAM, one port per buffer
    input  logic signed [`kFilteredDataLength-1:0]         fr0_val,
    input  logic signed [`kFilteredDataLength-1:0]         fr1_val,
    output logic [`kSLength-1:0]                           fr0_s_val,
    output logic [`kSLength-1:0]                           fr1_s_val,
    // PE row
    output logic                                           pe_reset,
    output logic                                           pe_kick,
    output logic                                           pe_en,
    output logic                                           pe_scan_mode,
    output logic                                           pe_scan_direction,
    output logic [`kFilteredDataLength*`kNoOfPartitions-1:0] pe_taps
);

    // table outputs for the current angle
    logic [`kAccuLength-1:0] mp_accu_part;
    logic [`kAccuLength-1:0] mp_accu_base;

    nabp_swap_if sw0_if ();
    nabp_swap_if sw1_if ();

    // offset and step per angle
    nabp_angle_lut angle_lut (
        .clk          (clk),
        .angle        (fr_angle),
        .mp_accu_part (mp_accu_part),
        .mp_accu_base (mp_accu_base)
    );

    nabp_swap_control swap_control (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr_angle          (fr_angle),
        .fr_has_next_angle (fr_has_next_angle),
        .fr_next_angle_ack (fr_next_angle_ack),
        .fr_next_angle     (fr_next_angle),
        .mp_accu_part      (mp_accu_part),
        .mp_accu_base      (mp_accu_base),
        .sw0               (sw0_if.ctrl),
        .sw1               (sw1_if.ctrl),
        .pe_reset          (pe_reset),
        .pe_kick           (pe_kick),
        .pe_en             (pe_en),
        .pe_scan_mode      (pe_scan_mode),
        .pe_scan_direction (pe_scan_direction),
        .pe_taps           (pe_taps)
    );

    // two identical buffers, roles swap every line
    nabp_swappable sw0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .sw       (sw0_if.sw),
        .fr_val   (fr0_val),
        .fr_s_val (fr0_s_val)
    );

    nabp_swappable sw1 (
        .clk      (clk),
        .reset_n  (reset_n),
        .sw       (sw1_if.sw),
        .fr_val   (fr1_val),
        .fr_s_val (fr1_s_val)
    );

endmodule

// ==== verif/nabp_swap_checker.sv ====
`timescale 1ns/1ps

module nabp_swap_checker (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  sw_sel,
    input nabp_pkg::ctrl_state_t state,
    input logic                  swap_ack,
    input logic                  fr_next_angle,
    input logic                  pe_kick,
    input logic                  pe_en
);

    // ------------------------------
    // swap control rules
    // ------------------------------
    // role select only flips after a swap
    sel_follows_swap: assert property (@(posedge clk)
        (reset_n && $past(reset_n) && sw_sel != $past(sw_sel)) |-> $past(swap_ack))
        else $error("sw_sel changed without swap_ack");

    // no angle request while held in reset
    no_request_in_reset: assert property (@(posedge clk)
        (!reset_n && !$past(reset_n)) |-> !fr_next_angle)
        else $error("fr_next_angle high during reset");

    // table value not settled before setup_3
    no_swap_in_early_setup: assert property (@(posedge clk)
        (state == nabp_pkg::ctrl_setup_1 || state == nabp_pkg::ctrl_setup_2) |-> !swap_ack)
        else $error("swap_ack in setup_1 or setup_2");

    // window opens right after the kick
    kick_then_enable: assert property (@(posedge clk) disable iff (!reset_n)
        pe_kick |=> pe_en)
        else $error("pe_en not high after pe_kick");

endmodule

bind nabp_swap_control nabp_swap_checker swap_checker (
    .clk           (clk),
    .reset_n       (reset_n),
    .sw_sel        (sw_sel),
    .state         (state),
    .swap_ack      (swap_ack),
    .fr_next_angle (fr_next_angle),
    .pe_kick       (pe_kick),
    .pe_en         (pe_en)
);

// ==== verif/nabp_processing_tb.sv ====
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_processing_tb;

    localparam int kTapsW = `kFilteredDataLength * `kNoOfPartitions;
    localparam int kMaxWin = 128;
    // 17 angles over all tests
    localparam int kTotalLines = 17 * `kPartitionSize;
    localparam int kWatchdog = kTotalLines * (`kShiftCycles + `kNoOfPartitions + 12) + 3000;
    localparam int kRunTimeout = 600;

    logic clk;
    logic reset_n;
    logic [`kAngleLength-1:0] fr_angle = '0;
    logic fr_has_next_angle = 1'b0;
    logic fr_next_angle_ack = 1'b0;
    logic signed [`kFilteredDataLength-1:0] fr0_val = '0;
    logic signed [`kFilteredDataLength-1:0] fr1_val = '0;
    logic fr_next_angle;
    logic [`kSLength-1:0] fr0_s_val;
    logic [`kSLength-1:0] fr1_s_val;
    logic pe_reset;
    logic pe_kick;
    logic pe_en;
    logic pe_scan_mode;
    logic pe_scan_direction;
    logic [kTapsW-1:0] pe_taps;

    // angle source setup, written by the tests only
    int angle_arr [16];
    int delay_arr [16];
    int n_angles = 0;
    int run_id = 0;
    // angle source private state
    int run_seen = 0;
    int src_idx = 0;
    int wait_cnt = -1;
    // window monitor
    logic pe_en_d = 1'b0;
    logic [kTapsW-1:0] got_taps [kMaxWin];
    logic got_mode [kMaxWin];
    logic got_dir [kMaxWin];
    int win_count = 0;
    int kick_count = 0;
    int reset_count = 0;
    int err_count = 0;
    int check_count = 0;
    int test_count = 0;
    logic [31:0] lcg_state = 32'd27;

    nabp_processing_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // helpers and reference model
    // ------------------------------
    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // filtered RAM content
    function automatic logic signed [`kFilteredDataLength-1:0] ram_sample(input logic [9:0] addr);
        int v;
        v = (int'(addr) * 7) % 2048 - 1024;
        return `kFilteredDataLength'(v);
    endfunction

    // taps of one line, from offset, step and the line start rule
    function automatic logic [kTapsW-1:0] ref_taps(input int angle, input int line);
        int step;
        int start;
        int addr;
        logic [kTapsW-1:0] v;
        step = (angle % 8) + 1;
        start = step * (`kPartitionSize - 1) + 16 - line * step;
        v = '0;
        for (int p = 0; p < `kNoOfPartitions; p++)
        begin
            addr = (start + p * step) % (1 << `kSLength);
            v[p*`kFilteredDataLength +: `kFilteredDataLength] = ram_sample(`kSLength'(addr));
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            $display("** Error %s: expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    // ------------------------------
    // RAM, angle source, monitor
    // ------------------------------
    always @(posedge clk)
    begin
        fr0_val <= ram_sample(fr0_s_val);
        fr1_val <= ram_sample(fr1_s_val);
    end

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            // source is not reset with the DUT, has_next keeps its level
            fr_next_angle_ack <= 1'b0;
            src_idx = n_angles;
            wait_cnt = -1;
        end
        else if (run_seen != run_id)
        begin
            // new run from the test
            run_seen = run_id;
            src_idx = 0;
            wait_cnt = -1;
            fr_has_next_angle <= (n_angles > 0);
        end
        else if (fr_next_angle_ack)
        begin
            // has_next held through the ack cycle
            fr_next_angle_ack <= 1'b0;
            fr_has_next_angle <= (src_idx < n_angles);
        end
        else if (fr_next_angle)
        begin
            if (wait_cnt < 0)
                wait_cnt = delay_arr[src_idx];
            if (wait_cnt == 0)
            begin
                fr_next_angle_ack <= 1'b1;
                fr_angle <= `kAngleLength'(angle_arr[src_idx]);
                src_idx++;
                wait_cnt = -1;
            end
            else
                wait_cnt--;
        end
    end

    // capture each pe_en window at its first cycle
    always @(posedge clk)
    begin
        pe_en_d <= pe_en;
        if (pe_kick)
            kick_count++;
        if (pe_reset)
            reset_count++;
        if (pe_en && !pe_en_d && win_count < kMaxWin)
        begin
            got_taps[win_count] = pe_taps;
            got_mode[win_count] = pe_scan_mode;
            got_dir[win_count] = pe_scan_direction;
            win_count++;
        end
    end

    initial
    begin
        repeat (kWatchdog) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    // ------------------------------
    // run control
    // ------------------------------
    task automatic start_run(input int count, input bit delayed);
        @(negedge clk);
        n_angles = count;
        for (int i = 0; i < count; i++)
            delay_arr[i] = delayed ? lcg_next() % 16 : 0;
        run_id++;
    endtask

    task automatic wait_windows(input string name, input int base, input int target);
        int cycles;
        cycles = 0;
        while ((win_count - base < target || pe_en) && cycles < kRunTimeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= kRunTimeout)
        begin
            $display("%s: only %0d of %0d windows seen in time", name, win_count - base, target);
            err_count++;
        end
    endtask

    // after the run nothing more may move
    task automatic idle_check(input string name, input int base, input int expected);
        bit bad;
        bad = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            if (fr_next_angle || pe_en)
                bad = 1'b1;
        end
        if (bad)
        begin
            $display("%s: angle request or pe_en seen after the last window", name);
            err_count++;
        end
        check({name, " windows"}, 64'(expected), 64'(win_count - base));
    endtask

    task automatic check_windows(input string name, input int base, input int count);
        int angle;
        for (int w = 0; w < count; w++)
        begin
            angle = angle_arr[w / `kPartitionSize];
            check({name, " taps"}, 64'(ref_taps(angle, w % `kPartitionSize)), 64'(got_taps[base+w]));
            check({name, " mode"}, 64'(angle < `kAngle45 || angle >= `kAngle135 ? 0 : 1),
                  64'(got_mode[base+w]));
            check({name, " dir"}, 64'(angle >= `kAngle90 ? 1 : 0), 64'(got_dir[base+w]));
        end
    endtask

    // one full run and its window compare
    task automatic full_run(input string name, input int count, input bit delayed);
        int base;
        int resets;
        base = win_count;
        resets = reset_count;
        start_run(count, delayed);
        wait_windows(name, base, count * `kPartitionSize);
        idle_check(name, base, count * `kPartitionSize);
        check_windows(name, base, count * `kPartitionSize);
        // one PE reset at the start of every run
        check({name, " pe_reset pulses"}, 64'(1), 64'(reset_count - resets));
    endtask

    task automatic report(input string name, input int err_before);
        test_count++;
        $display("test %s: %s, %0d errors", name,
                 err_count == err_before ? "ok" : "FAILED", err_count - err_before);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_single_angle();
        int e;
        e = err_count;
        angle_arr[0] = 30;
        full_run("single_angle", 1, 1'b0);
        report("single_angle", e);
    endtask

    task automatic test_angle_sequence(input bit delayed);
        int e;
        e = err_count;
        angle_arr[0] = 60;
        angle_arr[1] = 100;
        angle_arr[2] = 150;
        full_run(delayed ? "delayed_ack" : "angle_sequence", 3, delayed);
        report(delayed ? "delayed_ack" : "angle_sequence", e);
    endtask

    task automatic test_reset_mid_run();
        int e;
        int base;
        int got;
        e = err_count;
        angle_arr[0] = 60;
        angle_arr[1] = 100;
        angle_arr[2] = 150;
        base = win_count;
        start_run(3, 1'b0);
        wait_windows("reset_mid_run", base, 5);
        got = win_count - base;
        check_windows("reset_mid_run", base, got);
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (3)
        begin
            @(posedge clk);
            @(negedge clk);
            check("reset outputs", 64'b0,
                  64'({fr_next_angle, pe_en, pe_kick, pe_reset}));
        end
        @(posedge clk);
        reset_n <= 1'b1;
        angle_arr[0] = 170;
        full_run("reset_then_170", 1, 1'b0);
        report("reset_mid_run", e);
    endtask

    task automatic test_random_angles();
        int e;
        int kicks;
        e = err_count;
        for (int i = 0; i < 6; i++)
            angle_arr[i] = lcg_next() % 180;
        kicks = kick_count;
        full_run("random_angles", 6, 1'b0);
        check("random_angles kicks", 64'(6 * `kPartitionSize), 64'(kick_count - kicks));
        report("random_angles", e);
    endtask

    initial
    begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_single_angle();
        test_angle_sequence(1'b0);
        test_angle_sequence(1'b1);
        test_reset_mid_run();
        test_random_angles();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
logic/nabp_pkg.sv
logic/nabp_swap_if.sv
logic/nabp_angle_lut.sv
logic/nabp_swappable.sv
logic/nabp_swap_control.sv
logic/nabp_processing_top.sv
verif/nabp_swap_checker.sv
verif/nabp_processing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module nabp_processing_tb \
    -f sources.f \
    -o nabp_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/nabp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
